/* design/preg_consts.svh */
/*
 * widths and counts for the physical register tracking entry
 */
`ifndef PREG_CONSTS_SVH
`define PREG_CONSTS_SVH

// ==============================
// field widths
// ==============================
`define PREG_ID_W 7
`define IID_W     7
`define AREG_W    5

// ==============================
// slot counts and vector sizes
// ==============================
`define DIS_SLOTS 4
`define RET_SLOTS 4
`define PREG_NUM  96
`define AREG_NUM  32

`endif

/* design/preg_pkg.sv */
/*
 * state encodings and slot/entry structs for the preg tracking entry
 */
`include "preg_consts.svh"

package preg_pkg;

  // ==============================
  // state encodings
  // ==============================
  // lifecycle is one-hot, bit order matters to the decode in ctrl
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lifecycle_e;

  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_DONE = 1'b1
  } wb_e;

  // ==============================
  // slot and entry payloads
  // ==============================
  typedef struct packed {
    logic [`AREG_W-1:0]    dst_reg;
    logic [`IID_W-1:0]     iid;
    logic [`PREG_ID_W-1:0] rel_preg;
  } dis_slot_t;

  typedef struct packed {
    logic [`AREG_W-1:0]    dst_reg;
    logic [`IID_W-1:0]     iid;
    logic [`PREG_ID_W-1:0] rel_preg;
  } entry_info_t;

  // iid update arrives one cycle ahead of preg_vld
  typedef struct packed {
    logic              iid_updt_vld;
    logic [`IID_W-1:0] iid_updt_val;
    logic              preg_vld;
  } ret_slot_t;

endpackage

/* design/preg_lifecycle_ctrl.sv */
/*
 * lifecycle and write-back state machines of the preg entry
 * plus the release strobe and the retired-released-written-back flag
 */
`timescale 1ns/1ps

module preg_lifecycle_ctrl import preg_pkg::*; (
  input  logic sm_clk,
  input  logic cpurst_b,
  input  logic flush,
  input  logic async_flush,
  input  logic sync_reset,
  input  logic reset_mapped,
  input  logic create_any,
  input  logic dealloc_vld,
  input  logic dealloc_mask,
  input  logic release_vld,
  input  logic wb_vld,
  input  logic retire_vld,
  output logic state_alloc,
  output logic state_retire,
  output logic state_dealloc,
  output logic rel_fire,
  output logic wb_done,
  output logic retired_released_wb
);

  lifecycle_e cur_state;
  lifecycle_e next_state;
  wb_e        wb_state;
  wb_e        wb_next;
  logic       state_release;
  logic       wb_masked;

  // ==============================
  // lifecycle FSM
  // ==============================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cur_state <= DEALLOC;
    end else if (sync_reset) begin
      // mapped entries come back holding their architectural register
      cur_state <= reset_mapped ? RETIRE : DEALLOC;
    end else begin
      cur_state <= next_state;
    end
  end

  always_comb begin
    next_state = cur_state;
    case (cur_state)
      DEALLOC: begin
        if (dealloc_vld && !flush)
          next_state = WF_ALLOC;
      end
      WF_ALLOC: begin
        if (flush)
          next_state = DEALLOC;
        else if (create_any)
          next_state = ALLOC;
      end
      ALLOC: begin
        if (flush)
          next_state = DEALLOC;
        else if (release_vld)
          next_state = wb_masked ? DEALLOC : RELEASE;
        else if (retire_vld)
          next_state = RETIRE;
      end
      // retired producer, no flush path any more
      RETIRE: begin
        if (release_vld)
          next_state = wb_masked ? DEALLOC : RELEASE;
      end
      RELEASE: begin
        if (wb_masked)
          next_state = DEALLOC;
      end
      default: next_state = DEALLOC;
    endcase
  end

  // one-hot bits
  assign state_dealloc = cur_state[0];
  assign state_alloc   = cur_state[2];
  assign state_retire  = cur_state[3];
  assign state_release = cur_state[4];

  // ==============================
  // write-back FSM
  // ==============================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_state <= WB_IDLE;
    end else if (async_flush) begin
      wb_state <= WB_DONE;
    end else if (sync_reset) begin
      wb_state <= reset_mapped ? WB_DONE : WB_IDLE;
    end else if (create_any) begin
      wb_state <= WB_IDLE;
    end else begin
      wb_state <= wb_next;
    end
  end

  always_comb begin
    wb_next = wb_state;
    if (wb_state == WB_IDLE && wb_vld)
      wb_next = WB_DONE;
    else if (wb_state == WB_DONE && state_dealloc)
      wb_next = WB_IDLE;
  end

  // ==============================
  // strobes
  // ==============================
  assign wb_done   = (wb_state == WB_DONE);
  // dealloc_mask holds the preg back even when written back
  assign wb_masked = wb_done && !dealloc_mask;
  // match bits are only set in ALLOC, but retire_vld can linger
  assign rel_fire  = state_alloc && retire_vld;

  // the flush logic samples this in the retiring cycle itself
  assign retired_released_wb = (rel_fire || state_retire || state_release) ? wb_done : 1'b1;

  a_state_onehot: assert property (
    @(posedge sm_clk) disable iff (!cpurst_b) $onehot(cur_state)
  ) else $error("lifecycle state is not one-hot: %b", cur_state);

endmodule

/* design/preg_info_reg.sv */
/*
 * create slot select and entry information register
 */
`timescale 1ns/1ps
`include "preg_consts.svh"

module preg_info_reg import preg_pkg::*; (
  input  logic                       sm_clk,
  input  logic                       cpurst_b,
  input  logic                       sync_reset,
  input  logic [`AREG_W-1:0]         reset_dst_reg,
  input  logic [`DIS_SLOTS-1:0]      create_vld,
  input  dis_slot_t [`DIS_SLOTS-1:0] dis_slots,
  output entry_info_t                info,
  output logic                       create_any
);

  dis_slot_t create_sel;

  assign create_any = |create_vld;

  // AND-OR mux, relies on create_vld being one-hot
  always_comb begin
    create_sel = '0;
    for (int i = 0; i < `DIS_SLOTS; i++) begin
      if (create_vld[i])
        create_sel = create_sel | dis_slots[i];
    end
  end

  // ==============================
  // info register
  // ==============================
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      info <= '0;
    end else if (sync_reset) begin
      info.dst_reg  <= reset_dst_reg;
      info.iid      <= '0;
      info.rel_preg <= '0;
    end else if (create_any) begin
      info.dst_reg  <= create_sel.dst_reg;
      info.iid      <= create_sel.iid;
      info.rel_preg <= create_sel.rel_preg;
    end
  end

  a_create_onehot0: assert property (
    @(posedge sm_clk) disable iff (!cpurst_b) $onehot0(create_vld)
  ) else $error("more than one dispatch slot creates this entry: %b", create_vld);

endmodule

/* design/preg_retire_match.sv */
/*
 * per retire slot iid pre-compare and combined retire valid
 */
`timescale 1ns/1ps
`include "preg_consts.svh"

module preg_retire_match import preg_pkg::*; (
  input  logic                       sm_clk,
  input  logic                       cpurst_b,
  input  logic                       sync_reset,
  input  logic                       state_alloc,
  input  logic [`IID_W-1:0]          iid,
  input  ret_slot_t [`RET_SLOTS-1:0] ret_slots,
  output logic                       retire_vld
);

  logic [`RET_SLOTS-1:0] match_q;
  logic [`RET_SLOTS-1:0] preg_vld;

  // ==============================
  // match bits
  // ==============================
  // compare a cycle early so the retire path is one AND-OR
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      match_q <= '0;
    end else if (sync_reset) begin
      match_q <= '0;
    end else begin
      for (int i = 0; i < `RET_SLOTS; i++) begin
        if (ret_slots[i].iid_updt_vld)
          match_q[i] <= state_alloc && (iid == ret_slots[i].iid_updt_val);
      end
    end
  end

  // ==============================
  // retire valid
  // ==============================
  always_comb begin
    for (int i = 0; i < `RET_SLOTS; i++) begin
      preg_vld[i] = ret_slots[i].preg_vld;
    end
  end

  // each slot only counts with its own preg valid
  assign retire_vld = |(preg_vld & match_q);

endmodule

/* design/preg_vector_decode.sv */
/*
 * one-hot release and recovery vectors, gated by the control strobes
 */
`timescale 1ns/1ps
`include "preg_consts.svh"

module preg_vector_decode (
  input  logic [`PREG_ID_W-1:0] rel_preg,
  input  logic [`AREG_W-1:0]    dst_reg,
  input  logic                  rel_fire,
  input  logic                  state_retire,
  output logic [`PREG_NUM-1:0]  rel_preg_expand,
  output logic [`AREG_NUM-1:0]  dreg
);

  logic [`PREG_NUM-1:0] rel_onehot;
  logic [`AREG_NUM-1:0] dst_onehot;

  // preg numbers past the vector size decode to all zero
  assign rel_onehot = {{(`PREG_NUM-1){1'b0}}, 1'b1} << rel_preg;
  assign dst_onehot = {{(`AREG_NUM-1){1'b0}}, 1'b1} << dst_reg;

  // release only in the retiring cycle
  assign rel_preg_expand = rel_fire ? rel_onehot : '0;
  // recovery held for the whole retire state
  assign dreg = state_retire ? dst_onehot : '0;

  always_comb begin
    a_rel_in_range: assert final (!rel_fire || $onehot(rel_preg_expand))
      else $error("release of preg %0d falls outside the release vector", rel_preg);
  end

endmodule

/* design/preg_entry.sv */
/*
 * physical register tracking entry, top level
 * connects lifecycle control, info register, retire match and vector decode
 */
`timescale 1ns/1ps
`include "preg_consts.svh"

module preg_entry import preg_pkg::*; (
  input  logic                                sm_clk,
  input  logic                                cpurst_b,
  input  logic                                flush,
  input  logic                                async_flush,
  input  logic                                sync_reset,
  input  logic                                reset_mapped,
  input  logic [`AREG_W-1:0]                  reset_dst_reg,
  input  logic [`DIS_SLOTS-1:0]               create_vld,
  input  dis_slot_t [`DIS_SLOTS-1:0]          dis_slots,
  input  ret_slot_t [`RET_SLOTS-1:0]          ret_slots,
  input  logic                                dealloc_vld,
  input  logic                                dealloc_mask,
  input  logic                                release_vld,
  input  logic                                wb_vld,
  output logic                                cur_state_dealloc,
  output logic [`PREG_NUM-1:0]                rel_preg_expand,
  output logic [`AREG_NUM-1:0]                dreg,
  output logic                                retired_released_wb
);

  entry_info_t info;
  logic        create_any;
  logic        retire_vld;
  logic        state_alloc;
  logic        state_retire;
  logic        rel_fire;

  // ==============================
  // control
  // ==============================
  preg_lifecycle_ctrl u_ctrl (
    .sm_clk              (sm_clk),
    .cpurst_b            (cpurst_b),
    .flush               (flush),
    .async_flush         (async_flush),
    .sync_reset          (sync_reset),
    .reset_mapped        (reset_mapped),
    .create_any          (create_any),
    .dealloc_vld         (dealloc_vld),
    .dealloc_mask        (dealloc_mask),
    .release_vld         (release_vld),
    .wb_vld              (wb_vld),
    .retire_vld          (retire_vld),
    .state_alloc         (state_alloc),
    .state_retire        (state_retire),
    .state_dealloc       (cur_state_dealloc),
    .rel_fire            (rel_fire),
    .wb_done             (),
    .retired_released_wb (retired_released_wb)
  );

  // ==============================
  // datapath
  // ==============================
  preg_info_reg u_info (
    .sm_clk        (sm_clk),
    .cpurst_b      (cpurst_b),
    .sync_reset    (sync_reset),
    .reset_dst_reg (reset_dst_reg),
    .create_vld    (create_vld),
    .dis_slots     (dis_slots),
    .info          (info),
    .create_any    (create_any)
  );

  preg_retire_match u_match (
    .sm_clk      (sm_clk),
    .cpurst_b    (cpurst_b),
    .sync_reset  (sync_reset),
    .state_alloc (state_alloc),
    .iid         (info.iid),
    .ret_slots   (ret_slots),
    .retire_vld  (retire_vld)
  );

  preg_vector_decode u_decode (
    .rel_preg        (info.rel_preg),
    .dst_reg         (info.dst_reg),
    .rel_fire        (rel_fire),
    .state_retire    (state_retire),
    .rel_preg_expand (rel_preg_expand),
    .dreg            (dreg)
  );

endmodule

/* tests/preg_entry_model.svh */
/*
 * reference model of the preg entry
 * model state, output prediction and the per-clock step
 */
`ifndef PREG_ENTRY_MODEL_SVH
`define PREG_ENTRY_MODEL_SVH

lifecycle_e            m_life;
wb_e                   m_wb;
entry_info_t           m_info;
logic [`RET_SLOTS-1:0] m_match;

task automatic reset_model();
  m_life  = DEALLOC;
  m_wb    = WB_IDLE;
  m_info  = '0;
  m_match = '0;
endtask

// any slot with preg valid on top of a registered match
function automatic logic retire_hit();
  logic hit;
  hit = 1'b0;
  for (int i = 0; i < `RET_SLOTS; i++)
    hit = hit | (ret_slots[i].preg_vld & m_match[i]);
  return hit;
endfunction

function automatic logic [`PREG_NUM-1:0] release_vector();
  logic [`PREG_NUM-1:0] v;
  for (int i = 0; i < `PREG_NUM; i++)
    v[i] = (m_life == ALLOC) && retire_hit() && (i == int'(m_info.rel_preg));
  return v;
endfunction

function automatic logic [`AREG_NUM-1:0] recovery_vector();
  logic [`AREG_NUM-1:0] v;
  for (int i = 0; i < `AREG_NUM; i++)
    v[i] = (m_life == RETIRE) && (i == int'(m_info.dst_reg));
  return v;
endfunction

function automatic logic rrwb_flag();
  logic busy;
  busy = ((m_life == ALLOC) && retire_hit()) || (m_life == RETIRE) || (m_life == RELEASE);
  return busy ? (m_wb == WB_DONE) : 1'b1;
endfunction

// one rising edge, using the inputs seen before it
task automatic step_model();
  lifecycle_e life_n;
  wb_e        wb_n;
  logic       freed;
  freed  = (m_wb == WB_DONE) && !dealloc_mask;
  life_n = m_life;
  case (m_life)
    DEALLOC:  life_n = (dealloc_vld && !flush) ? WF_ALLOC : DEALLOC;
    WF_ALLOC: life_n = flush ? DEALLOC : ((|create_vld) ? ALLOC : WF_ALLOC);
    ALLOC: begin
      if (flush)
        life_n = DEALLOC;
      else if (release_vld)
        life_n = freed ? DEALLOC : RELEASE;
      else if (retire_hit())
        life_n = RETIRE;
    end
    RETIRE:   life_n = release_vld ? (freed ? DEALLOC : RELEASE) : RETIRE;
    RELEASE:  life_n = freed ? DEALLOC : RELEASE;
    default:  life_n = DEALLOC;
  endcase
  if (sync_reset)
    life_n = reset_mapped ? RETIRE : DEALLOC;
  wb_n = m_wb;
  if (async_flush)
    wb_n = WB_DONE;
  else if (sync_reset)
    wb_n = reset_mapped ? WB_DONE : WB_IDLE;
  else if (|create_vld)
    wb_n = WB_IDLE;
  else if (m_wb == WB_IDLE && wb_vld)
    wb_n = WB_DONE;
  else if (m_wb == WB_DONE && m_life == DEALLOC)
    wb_n = WB_IDLE;
  // match bits see the old state and the old iid
  for (int i = 0; i < `RET_SLOTS; i++) begin
    if (sync_reset)
      m_match[i] = 1'b0;
    else if (ret_slots[i].iid_updt_vld)
      m_match[i] = (m_life == ALLOC) && (m_info.iid == ret_slots[i].iid_updt_val);
  end
  if (sync_reset) begin
    m_info         = '0;
    m_info.dst_reg = reset_dst_reg;
  end else begin
    for (int i = 0; i < `DIS_SLOTS; i++) begin
      if (create_vld[i]) begin
        m_info.dst_reg  = dis_slots[i].dst_reg;
        m_info.iid      = dis_slots[i].iid;
        m_info.rel_preg = dis_slots[i].rel_preg;
      end
    end
  end
  m_life = life_n;
  m_wb   = wb_n;
  if (!cpurst_b)
    reset_model();
endtask

`endif

/* tests/tb_preg_entry.sv */
/*
 * testbench for the preg tracking entry
 * directed lifecycle tests and a random mix against the reference model
 */
`timescale 1ns/1ps
`include "preg_consts.svh"

module tb_preg_entry import preg_pkg::*; ();

  // cycle budget per test and 200 spare cycles for the timeout
  localparam int RESET_LEN    = 16;
  localparam int DIRECTED_LEN = 1 + 12 + 48 + 15 + 16;
  localparam int RANDOM_LEN   = 2000;
  localparam int CYCLE_LIMIT  = RESET_LEN + DIRECTED_LEN + RANDOM_LEN + 200;
  localparam int WAIT_MAX     = 4;

  logic                       sm_clk = 1'b0;
  logic                       cpurst_b;
  logic                       flush;
  logic                       async_flush;
  logic                       sync_reset;
  logic                       reset_mapped;
  logic [`AREG_W-1:0]         reset_dst_reg;
  logic [`DIS_SLOTS-1:0]      create_vld;
  dis_slot_t [`DIS_SLOTS-1:0] dis_slots;
  ret_slot_t [`RET_SLOTS-1:0] ret_slots;
  logic                       dealloc_vld;
  logic                       dealloc_mask;
  logic                       release_vld;
  logic                       wb_vld;
  logic                       cur_state_dealloc;
  logic [`PREG_NUM-1:0]       rel_preg_expand;
  logic [`AREG_NUM-1:0]       dreg;
  logic                       retired_released_wb;

  int          err_total;
  int          test_errs;
  int          tests_passed;
  int          tests_failed;
  int          cycle_cnt = 0;
  entry_info_t sel_info;

  preg_entry i_dut (.*);

  `include "preg_entry_model.svh"

  always #4 sm_clk = ~sm_clk;

  always @(posedge sm_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==============================
  // helpers
  // ==============================
  function automatic logic [31:0] rnd32();
    return $urandom();
  endfunction

  task automatic check_val(string test, string what, logic [95:0] exp, logic [95:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h, actual %h", test, what, exp, act);
      test_errs++;
      err_total++;
    end
  endtask

  // outputs are settled at the falling edge
  task automatic sample(string test);
    @(negedge sm_clk);
    check_val(test, "cur_state_dealloc", 96'(m_life == DEALLOC), 96'(cur_state_dealloc));
    check_val(test, "rel_preg_expand", release_vector(), rel_preg_expand);
    check_val(test, "dreg", 96'(recovery_vector()), 96'(dreg));
    check_val(test, "retired_released_wb", 96'(rrwb_flag()), 96'(retired_released_wb));
  endtask

  task automatic advance();
    @(posedge sm_clk);
    step_model();
  endtask

  task automatic cycle(string test);
    sample(test);
    advance();
  endtask

  task automatic finish_test(string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic wait_dealloc(string test);
    int n;
    n = 0;
    sample(test);
    while (!cur_state_dealloc && n < WAIT_MAX) begin
      advance();
      sample(test);
      n++;
    end
    if (!cur_state_dealloc) begin
      $display("test %s: entry still not back in dealloc after %0d cycles", test, WAIT_MAX);
      test_errs++;
      err_total++;
    end
    advance();
  endtask

  // dealloc, then create from one random dispatch slot
  task automatic allocate_entry(string test);
    dis_slot_t [`DIS_SLOTS-1:0] slots;
    logic [31:0]                r;
    dealloc_vld <= 1'b1;
    cycle(test);
    dealloc_vld <= 1'b0;
    for (int i = 0; i < `DIS_SLOTS; i++) begin
      r = rnd32();
      slots[i].dst_reg  = r[4:0];
      slots[i].iid      = r[11:5];
      slots[i].rel_preg = 7'(r[31:12] % 96);
    end
    r = rnd32();
    sel_info.dst_reg  = slots[r[1:0]].dst_reg;
    sel_info.iid      = slots[r[1:0]].iid;
    sel_info.rel_preg = slots[r[1:0]].rel_preg;
    create_vld <= 4'b0001 << r[1:0];
    dis_slots  <= slots;
    cycle(test);
    create_vld <= '0;
  endtask

  // iid update, then preg valid on the same retire slot
  task automatic retire_entry(string test);
    ret_slot_t rs;
    int        k;
    k = int'(rnd32() % 32'd4);
    rs = '0;
    rs.iid_updt_vld = 1'b1;
    rs.iid_updt_val = sel_info.iid;
    ret_slots[k] <= rs;
    cycle(test);
    rs = '0;
    rs.preg_vld = 1'b1;
    ret_slots[k] <= rs;
    sample(test);
    check_val(test, "rel_preg_expand", 96'(1) << sel_info.rel_preg, rel_preg_expand);
    advance();
    ret_slots <= '0;
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic reset_state_test();
    sample("after_reset");
    check_val("after_reset", "cur_state_dealloc", 96'(1), 96'(cur_state_dealloc));
    check_val("after_reset", "rel_preg_expand", '0, rel_preg_expand);
    check_val("after_reset", "dreg", '0, 96'(dreg));
    advance();
    finish_test("after_reset");
  endtask

  task automatic full_life_test();
    allocate_entry("full_life");
    retire_entry("full_life");
    sample("full_life");
    check_val("full_life", "dreg", 96'(32'(1) << sel_info.dst_reg), 96'(dreg));
    check_val("full_life", "rel_preg_expand", '0, rel_preg_expand);
    advance();
    wb_vld <= 1'b1;
    cycle("full_life");
    wb_vld      <= 1'b0;
    release_vld <= 1'b1;
    cycle("full_life");
    release_vld <= 1'b0;
    wait_dealloc("full_life");
    finish_test("full_life");
  endtask

  task automatic release_order_test();
    logic wb_first;
    logic mask;
    for (int s = 0; s < 4; s++) begin
      wb_first = s[0];
      mask     = s[1];
      allocate_entry("release_order");
      retire_entry("release_order");
      if (wb_first) begin
        wb_vld <= 1'b1;
        cycle("release_order");
        wb_vld <= 1'b0;
      end
      dealloc_mask <= mask;
      release_vld  <= 1'b1;
      cycle("release_order");
      release_vld <= 1'b0;
      sample("release_order");
      // freed at once only when written back and unmasked
      check_val("release_order", "cur_state_dealloc", 96'(wb_first && !mask),
                96'(cur_state_dealloc));
      advance();
      if (!wb_first) begin
        wb_vld <= 1'b1;
        cycle("release_order");
        wb_vld <= 1'b0;
      end
      dealloc_mask <= 1'b0;
      wait_dealloc("release_order");
    end
    finish_test("release_order");
  endtask

  task automatic flush_test();
    ret_slot_t rs;
    dealloc_vld <= 1'b1;
    cycle("flush");
    dealloc_vld <= 1'b0;
    flush       <= 1'b1;
    sample("flush");
    check_val("flush", "retired_released_wb", 96'(1), 96'(retired_released_wb));
    advance();
    flush <= 1'b0;
    sample("flush");
    check_val("flush", "cur_state_dealloc", 96'(1), 96'(cur_state_dealloc));
    advance();
    // flush in the retiring cycle and an async flush ahead of it on the second pass
    for (int a = 0; a < 2; a++) begin
      allocate_entry("flush");
      if (a == 1) begin
        async_flush <= 1'b1;
        cycle("flush");
        async_flush <= 1'b0;
      end
      rs = '0;
      rs.iid_updt_vld = 1'b1;
      rs.iid_updt_val = sel_info.iid;
      ret_slots[0] <= rs;
      cycle("flush");
      rs = '0;
      rs.preg_vld = 1'b1;
      ret_slots[0] <= rs;
      flush        <= 1'b1;
      sample("flush");
      check_val("flush", "retired_released_wb", 96'(a), 96'(retired_released_wb));
      advance();
      flush     <= 1'b0;
      ret_slots <= '0;
      sample("flush");
      check_val("flush", "cur_state_dealloc", 96'(1), 96'(cur_state_dealloc));
      advance();
    end
    finish_test("flush");
  endtask

  task automatic sync_reset_test();
    logic [31:0] r;
    for (int m = 0; m < 2; m++) begin
      r = rnd32();
      sync_reset    <= 1'b1;
      reset_mapped  <= m[0];
      reset_dst_reg <= r[4:0];
      cycle("sync_reset");
      sync_reset <= 1'b0;
      sample("sync_reset");
      check_val("sync_reset", "dreg", 96'((m == 1) ? 32'(1) << r[4:0] : 32'(0)), 96'(dreg));
      check_val("sync_reset", "cur_state_dealloc", 96'(m == 0), 96'(cur_state_dealloc));
      advance();
      // a mapped entry comes back written back, so release frees it
      release_vld <= m[0];
      cycle("sync_reset");
      release_vld <= 1'b0;
      wait_dealloc("sync_reset");
    end
    finish_test("sync_reset");
  endtask

  task automatic random_mix_test();
    logic [31:0]                r;
    dis_slot_t [`DIS_SLOTS-1:0] ds;
    ret_slot_t [`RET_SLOTS-1:0] rs;
    for (int c = 0; c < RANDOM_LEN; c++) begin
      r = rnd32();
      flush         <= (r[4:0] == 5'd0);
      async_flush   <= (r[10:5] == 6'd0);
      sync_reset    <= (r[17:11] == 7'd0);
      reset_mapped  <= r[18];
      dealloc_vld   <= r[19];
      dealloc_mask  <= (r[21:20] == 2'd0);
      release_vld   <= (r[24:22] == 3'd0);
      wb_vld        <= (r[26:25] == 2'd0);
      reset_dst_reg <= r[31:27];
      r = rnd32();
      create_vld <= (r[1:0] == 2'd0) ? (4'b0001 << r[3:2]) : 4'b0000;
      // small iid range so retire updates often hit the entry
      for (int i = 0; i < `DIS_SLOTS; i++) begin
        r = rnd32();
        ds[i].dst_reg  = r[4:0];
        ds[i].iid      = {4'b0000, r[7:5]};
        ds[i].rel_preg = 7'(r[31:8] % 96);
      end
      for (int i = 0; i < `RET_SLOTS; i++) begin
        r = rnd32();
        rs[i].iid_updt_vld = r[0];
        rs[i].iid_updt_val = {4'b0000, r[3:1]};
        rs[i].preg_vld     = (r[5:4] == 2'd0);
      end
      dis_slots <= ds;
      ret_slots <= rs;
      cycle("random_mix");
    end
    finish_test("random_mix");
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    void'($urandom(32'h1fac));
    cpurst_b      <= 1'b0;
    flush         <= 1'b0;
    async_flush   <= 1'b0;
    sync_reset    <= 1'b0;
    reset_mapped  <= 1'b0;
    reset_dst_reg <= '0;
    create_vld    <= '0;
    dis_slots     <= '0;
    ret_slots     <= '0;
    dealloc_vld   <= 1'b0;
    dealloc_mask  <= 1'b0;
    release_vld   <= 1'b0;
    wb_vld        <= 1'b0;
    err_total     = 0;
    test_errs     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    sel_info      = '0;
    reset_model();
    repeat (RESET_LEN) cycle("reset");
    cpurst_b <= 1'b1;
    reset_state_test();
    full_life_test();
    release_order_test();
    flush_test();
    sync_reset_test();
    random_mix_test();
    $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, err_total);
    if (tests_failed == 0 && err_total == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
+incdir+tests
design/preg_pkg.sv
design/preg_lifecycle_ctrl.sv
design/preg_info_reg.sv
design/preg_retire_match.sv
design/preg_vector_decode.sv
design/preg_entry.sv
tests/tb_preg_entry.sv

/* run_sim.sh */
#!/bin/sh
# build and run the preg entry testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_preg_entry \
  -Mdir obj_dir -o tb_preg_entry
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_preg_entry)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
